// File: bench/rom_loader_stim.txt
# kind [addr data], hex: L start, B byte, E end, Q reset request, T reset timing, X end
# C cpu_byte_addr expected_byte, S sprite_word_addr expected_word
L
B 0000 3c
B 0001 a5
B 1235 7e
B 10000 11
B 12000 22
B 14000 33
B 16000 44
B 18000 99
E
T
C 0000 3c
C 0001 a5
C 1235 7e
S 0000 44332211
B 0001 5a
C 0001 a5
Q
T
L
B 0000 c3
C 1235 00
S 0000 00000000
E
T
C 0000 c3
C 0001 a5
C 1235 7e
S 0000 44332211
X

// File: bench/rom_loader_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rom_loader_tb
	import rom_map_pkg::*;
	import core_ctrl_pkg::*;
();

	localparam int CLK_HALF = 50;
	localparam int DRIVE_DLY = 10;

	logic clk_sys = 1'b0;
	logic rst;
	logic ioctl_download;
	logic ioctl_wr;
	logic [IOCTL_AW-1:0] ioctl_addr;
	logic [7:0] ioctl_dout;
	logic reset_req;
	logic [15:0] cpu_rom_addr;
	logic [SPR_WORDS_AW-1:0] sp_addr;
	logic [7:0] cpu_rom_do;
	logic [31:0] sp_do;
	logic rom_loaded;
	logic core_reset;

	logic [7:0] rec_kind[$];
	logic [31:0] rec_a[$];
	logic [31:0] rec_b[$];
	int cycle_limit = 0;
	int run_cycles = 0;
	int cycle_no = 0;
	int drop_cycle = 0;
	int expect_fall = 0;
	int fall_cycle = -1;
	int rise_cycle = -1;
	bit first_load = 1'b0;
	bit image_loaded = 1'b0;
	bit reset_prev = 1'b1;

	rom_loader_top dut_i (.*);

	always #CLK_HALF clk_sys = ~clk_sys;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	always @(posedge clk_sys) begin
		run_cycles = run_cycles + 1;
		if (cycle_limit > 0 && run_cycles > cycle_limit)
			abort_run("timeout, the records did not complete in the cycle budget");
	end

	task automatic check_val(input string name, input logic [31:0] act, input logic [31:0] exp);
		if (act !== exp) begin
			$display("ERR %0t %s: got %h, expected %h", $time, name, act, exp);
			$display("Simulation FAILED");
			$fatal(1);
		end
	endtask

	// advance one edge and watch rom_loaded and core_reset
	task automatic tick();
		@(posedge clk_sys);
		#DRIVE_DLY;
		cycle_no++;
		if (rom_loaded === 1'b1 && rise_cycle < 0)
			rise_cycle = cycle_no;
		if (reset_prev && core_reset === 1'b0 && fall_cycle < 0)
			fall_cycle = cycle_no;
		reset_prev = (core_reset === 1'b1);
	endtask

	task automatic load_byte(input logic [31:0] addr, input logic [31:0] data);
		ioctl_addr = addr[IOCTL_AW-1:0];
		ioctl_dout = data[7:0];
		ioctl_wr = 1'b1;
		tick();
		ioctl_wr = 1'b0;
		repeat (3) tick();  // idle gap between bytes
	endtask

	task automatic read_cpu(input logic [31:0] addr, input logic [31:0] exp);
		cpu_rom_addr = addr[15:0];
		repeat (2) tick();  // bank read + reader register
		check_val("cpu_rom_do", {24'd0, cpu_rom_do}, exp);
		if (ioctl_download) begin
			check_val("core_reset", {31'd0, core_reset}, 32'd1);
			check_val("rom_loaded", {31'd0, rom_loaded}, {31'd0, image_loaded});
		end
	endtask

	task automatic read_sprite(input logic [31:0] addr, input logic [31:0] exp);
		sp_addr = addr[SPR_WORDS_AW-1:0];
		repeat (2) tick();
		check_val("sp_do", sp_do, exp);
		if (ioctl_download) begin
			check_val("core_reset", {31'd0, core_reset}, 32'd1);
			check_val("rom_loaded", {31'd0, rom_loaded}, {31'd0, image_loaded});
		end
	endtask

	task automatic end_download();
		ioctl_download = 1'b0;
		drop_cycle = cycle_no;
		expect_fall = cycle_no + 2 + RESET_HOLD + 2;  // rom_loaded delay, then the hold
		first_load = (rise_cycle < 0);
		image_loaded = 1'b1;
		fall_cycle = -1;
	endtask

	task automatic pulse_reset_req();
		reset_req = 1'b1;
		expect_fall = cycle_no + RESET_HOLD + 2;
		first_load = 1'b0;
		fall_cycle = -1;
		tick();
		reset_req = 1'b0;
		check_val("core_reset", {31'd0, core_reset}, 32'd1);
	endtask

	task automatic check_reset_timing();
		while (core_reset === 1'b1)
			tick();
		check_val("core_reset fall cycle", fall_cycle, expect_fall);
		if (first_load)
			check_val("rom_loaded rise cycle", rise_cycle, drop_cycle + 2);
	endtask

	initial begin
		int fd;
		int r;
		bit done;
		logic [8*8-1:0] tok;
		logic [8*120-1:0] line;
		logic [31:0] a;
		logic [31:0] b;
		rst = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		reset_req = 1'b0;
		cpu_rom_addr = '0;
		sp_addr = '0;

		fd = $fopen("bench/rom_loader_stim.txt", "r");
		if (fd == 0)
			abort_run("could not open bench/rom_loader_stim.txt");
		done = 1'b0;
		while (!done) begin
			a = '0;
			b = '0;
			r = $fscanf(fd, "%s", tok);
			if (r != 1)
				abort_run("stimulus file ended without its X end marker");
			if (tok == "#") begin
				r = $fgets(line, fd);  // comment line
			end else if (tok == "X") begin
				done = 1'b1;
			end else begin
				if (tok == "B" || tok == "C" || tok == "S") begin
					r = $fscanf(fd, "%h %h", a, b);
					if (r != 2)
						abort_run("stimulus record is missing its address or value");
				end else if (tok != "L" && tok != "E" && tok != "Q" && tok != "T") begin
					abort_run("unknown record kind in stimulus file");
				end
				rec_kind.push_back(tok[7:0]);
				rec_a.push_back(a);
				rec_b.push_back(b);
			end
		end
		$fclose(fd);
		cycle_limit = 4 * rec_kind.size() * 8 + 200;

		repeat (5) tick();
		rst = 1'b0;
		repeat (2) tick();
		// idle after reset with nothing loaded
		check_val("core_reset", {31'd0, core_reset}, 32'd1);
		check_val("rom_loaded", {31'd0, rom_loaded}, 32'd0);
		check_val("cpu_rom_do", {24'd0, cpu_rom_do}, 32'd0);
		check_val("sp_do", sp_do, 32'd0);

		for (int i = 0; i < rec_kind.size(); i++) begin
			case (rec_kind[i])
				"L": begin
					ioctl_download = 1'b1;
					tick();
				end
				"B": load_byte(rec_a[i], rec_b[i]);
				"E": end_download();
				"C": read_cpu(rec_a[i], rec_b[i]);
				"S": read_sprite(rec_a[i], rec_b[i]);
				"Q": pulse_reset_req();
				"T": check_reset_timing();
				default: abort_run("bad record kind while running");
			endcase
		end

		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: logic/core_ctrl_pkg.sv
`default_nettype none

package core_ctrl_pkg;

	// cycles of core reset after release
	localparam int RESET_HOLD = 16;
	localparam int HOLD_W = $clog2(RESET_HOLD + 1);

	typedef enum logic [1:0] {
		st_wait_rom,  // nothing loaded yet
		st_loading,
		st_hold,
		st_run
	} seq_state_t;

endpackage

`default_nettype wire

// File: logic/load_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module load_sequencer
	import core_ctrl_pkg::*;
(
	input logic clk_sys,
	input logic rst,
	input logic ioctl_download,
	input logic ioctl_wr,
	input logic reset_req,
	rom_port_if.ctrl cpu_port,
	rom_port_if.ctrl spr_port,
	output logic capture,
	output logic loading,
	output logic rom_loaded,
	output logic core_reset
);

	seq_state_t state;
	logic wr_last;
	logic dl_q;
	logic dl_q2;
	logic reload;
	logic [HOLD_W-1:0] hold_cnt;

	assign capture = ioctl_download & ioctl_wr & ~wr_last;  // rising edge of ioctl_wr
	assign loading = ioctl_download | ~rom_loaded;  // no valid image before first load
	assign reload = reset_req | (state == st_wait_rom) | (state == st_loading);

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			wr_last <= 1'b0;
			dl_q <= 1'b0;
			dl_q2 <= 1'b0;
		end else begin
			wr_last <= ioctl_wr;
			dl_q <= ioctl_download;
			dl_q2 <= dl_q;
		end
	end

	// one toggle per byte, each bank copies it back into ack
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cpu_port.req <= 1'b0;
			spr_port.req <= 1'b0;
		end else if (capture) begin
			cpu_port.req <= ~cpu_port.req;
			spr_port.req <= ~spr_port.req;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state <= st_wait_rom;
		end else begin
			case (state)
				st_wait_rom: if (dl_q2) state <= st_loading;
				st_loading: if (!dl_q2) state <= st_hold;
				st_hold: begin
					if (dl_q2)
						state <= st_loading;
					else if (hold_cnt == '0 && !reset_req)
						state <= st_run;
				end
				st_run: begin
					if (dl_q2)
						state <= st_loading;
					else if (reset_req)
						state <= st_hold;
				end
				default: state <= st_wait_rom;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			hold_cnt <= HOLD_W'(RESET_HOLD);
			core_reset <= 1'b1;
			rom_loaded <= 1'b0;
		end else begin
			if (reload)
				hold_cnt <= HOLD_W'(RESET_HOLD);
			else if (hold_cnt != '0)
				hold_cnt <= hold_cnt - 1'b1;
			core_reset <= reload | (hold_cnt != '0);
			if (dl_q2 & ~dl_q)
				rom_loaded <= 1'b1;  // sticky, end of first download
		end
	end

endmodule

`default_nettype wire

// File: logic/rom_addr_map.sv
`timescale 1ns/10ps
`default_nettype none

module rom_addr_map
	import rom_map_pkg::*;
(
	input logic clk_sys,
	input logic rst,
	input logic capture,
	input logic [IOCTL_AW-1:0] ioctl_addr,
	input logic [7:0] ioctl_dout,
	rom_port_if.map cpu_port,
	rom_port_if.map spr_port
);

	rom_region_t region;
	logic [IOCTL_AW-1:0] spr_off;

	assign spr_off = ioctl_addr - SPR_BASE;

	always_comb begin
		if (ioctl_addr < SPR_BASE)
			region = region_cpu;
		else if (ioctl_addr < SPR_END)
			region = region_sprite;
		else
			region = region_none;
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cpu_port.be <= '0;
			spr_port.be <= '0;
		end else if (capture) begin
			cpu_port.be <= '0;
			spr_port.be <= '0;
			if (region == region_cpu)
				cpu_port.be <= ioctl_addr[0] ? 2'b10 : 2'b01;  // odd byte -> high lane
			else if (region == region_sprite)
				spr_port.be <= 4'b0001 << spr_off[SPR_WORDS_AW +: SPR_LANE_W];
		end
	end

	// four 8 KB roms merged into one 32-bit word
	always_ff @(posedge clk_sys) begin
		if (capture) begin
			cpu_port.addr <= ioctl_addr[CPU_WORDS_AW:1];
			spr_port.addr <= spr_off[SPR_WORDS_AW-1:0];
			cpu_port.wdata <= {2{ioctl_dout}};
			spr_port.wdata <= {4{ioctl_dout}};
		end
	end

endmodule

`default_nettype wire

// File: logic/rom_bank.sv
`timescale 1ns/10ps
`default_nettype none

module rom_bank #(
	parameter int DATA_BYTES = 2,
	parameter int ADDR_W = 15
) (
	input logic clk_sys,
	input logic rst,
	rom_port_if.bank wr,
	input logic [ADDR_W-1:0] rd_addr,
	output logic [8*DATA_BYTES-1:0] rd_data
);

	logic [8*DATA_BYTES-1:0] mem [2**ADDR_W];
	logic wr_pend;

	assign wr_pend = wr.req != wr.ack;

	always_ff @(posedge clk_sys) begin
		if (wr_pend) begin
			for (int i = 0; i < DATA_BYTES; i++) begin
				if (wr.be[i])
					mem[wr.addr][8*i +: 8] <= wr.wdata[8*i +: 8];
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			wr.ack <= 1'b0;
			rd_data <= '0;
		end else begin
			wr.ack <= wr.req;  // done, same edge as the write
			rd_data <= mem[rd_addr];
		end
	end

endmodule

`default_nettype wire

// File: logic/rom_loader_top.sv
`timescale 1ns/10ps
`default_nettype none

module rom_loader_top
	import rom_map_pkg::*;
(
	input logic clk_sys,
	input logic rst,
	input logic ioctl_download,
	input logic ioctl_wr,
	input logic [IOCTL_AW-1:0] ioctl_addr,
	input logic [7:0] ioctl_dout,
	input logic reset_req,
	input logic [15:0] cpu_rom_addr,
	input logic [SPR_WORDS_AW-1:0] sp_addr,
	output logic [7:0] cpu_rom_do,
	output logic [31:0] sp_do,
	output logic rom_loaded,
	output logic core_reset
);

	logic capture;
	logic loading;
	logic [15:0] cpu_word;
	logic [31:0] spr_word;

	rom_port_if #(.DATA_BYTES(2), .ADDR_W(CPU_WORDS_AW)) cpu_port ();
	rom_port_if #(.DATA_BYTES(4), .ADDR_W(SPR_WORDS_AW)) spr_port ();

	load_sequencer seq_i (
		.clk_sys        (clk_sys),
		.rst            (rst),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.reset_req      (reset_req),
		.cpu_port       (cpu_port),
		.spr_port       (spr_port),
		.capture        (capture),
		.loading        (loading),
		.rom_loaded     (rom_loaded),
		.core_reset     (core_reset)
	);

	rom_addr_map map_i (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.capture    (capture),
		.ioctl_addr (ioctl_addr),
		.ioctl_dout (ioctl_dout),
		.cpu_port   (cpu_port),
		.spr_port   (spr_port)
	);

	// main + sound program, 16-bit words
	rom_bank #(.DATA_BYTES(2), .ADDR_W(CPU_WORDS_AW)) cpu_bank (
		.clk_sys (clk_sys),
		.rst     (rst),
		.wr      (cpu_port),
		.rd_addr (cpu_rom_addr[CPU_WORDS_AW:1]),
		.rd_data (cpu_word)
	);

	rom_bank #(.DATA_BYTES(4), .ADDR_W(SPR_WORDS_AW)) spr_bank (
		.clk_sys (clk_sys),
		.rst     (rst),
		.wr      (spr_port),
		.rd_addr (sp_addr),
		.rd_data (spr_word)
	);

	rom_reader reader_i (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.loading    (loading),
		.cpu_word   (cpu_word),
		.cpu_lane   (cpu_rom_addr[0]),
		.spr_word   (spr_word),
		.cpu_rom_do (cpu_rom_do),
		.sp_do      (sp_do)
	);

endmodule

`default_nettype wire

// File: logic/rom_map_pkg.sv
`default_nettype none

package rom_map_pkg;

	// download stream
	localparam int IOCTL_AW = 25;

	// word address widths of the two banks
	localparam int CPU_WORDS_AW = 15;  // 32K x 16, main + sound program
	localparam int SPR_WORDS_AW = 13;  // 8K x 32

	// sprite roms sit one per byte lane, lane select just above the word address
	localparam int SPR_LANE_W = 2;

	localparam logic [IOCTL_AW-1:0] SPR_BASE = 25'h001_0000;
	localparam logic [IOCTL_AW-1:0] SPR_END  = 25'h001_8000;  // first byte past sprites

	typedef enum logic [1:0] {
		region_cpu,
		region_sprite,
		region_none
	} rom_region_t;

endpackage

`default_nettype wire

// File: logic/rom_port_if.sv
`timescale 1ns/10ps
`default_nettype none

// write pending while req != ack
interface rom_port_if #(
	parameter int DATA_BYTES = 2,
	parameter int ADDR_W = 15
);
	logic req;
	logic ack;
	logic [ADDR_W-1:0] addr;
	logic [DATA_BYTES-1:0] be;
	logic [8*DATA_BYTES-1:0] wdata;  // byte copied to every lane

	modport ctrl (output req);
	modport map (output addr, output be, output wdata);
	modport bank (input req, input addr, input be, input wdata, output ack);

endinterface

`default_nettype wire

// File: logic/rom_reader.sv
`timescale 1ns/10ps
`default_nettype none

module rom_reader (
	input logic clk_sys,
	input logic rst,
	input logic loading,
	input logic [15:0] cpu_word,
	input logic cpu_lane,
	input logic [31:0] spr_word,
	output logic [7:0] cpu_rom_do,
	output logic [31:0] sp_do
);

	logic lane_q;  // lines up with the bank read

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			lane_q <= 1'b0;
			cpu_rom_do <= '0;
			sp_do <= '0;
		end else begin
			lane_q <= cpu_lane;
			if (loading) begin
				cpu_rom_do <= '0;
				sp_do <= '0;
			end else begin
				cpu_rom_do <= lane_q ? cpu_word[15:8] : cpu_word[7:0];
				sp_do <= spr_word;
			end
		end
	end

endmodule

`default_nettype wire

// File: rom_loader_top.f
logic/rom_map_pkg.sv
logic/core_ctrl_pkg.sv
logic/rom_port_if.sv
logic/load_sequencer.sv
logic/rom_addr_map.sv
logic/rom_bank.sv
logic/rom_reader.sv
logic/rom_loader_top.sv
bench/rom_loader_tb.sv
